//--- design/elink_pkg.sv
// shared types and constants for the elink transmit front end
// every design and bench file pulls these in with a wildcard import
package elink_pkg;

   // ########################################################################
   // mesh packet
   // ########################################################################

   // 104 bit mesh packet, msb first as it sits on the write port
   typedef struct packed {
      logic        write;     // 1 = write, 0 = read
      logic [1:0]  datamode;  // transfer size code
      logic [4:0]  ctrlmode;  // routing / special ops
      logic [31:0] dstaddr;   // target address
      logic [31:0] data;      // write data (or low word)
      logic [31:0] srcaddr;   // return address for reads
   } emesh_packet_t;

   // ########################################################################
   // configuration register map
   // ########################################################################

   // register index lives in dstaddr[RFAW+1:2]
   // indices above reg_chipid are not config registers
   typedef enum logic [1:0] {
      reg_reset  = 2'd0,  // bit0 tx soft reset, bit1 rx soft reset
      reg_clk    = 2'd1,  // clock config word for the pll
      reg_chipid = 2'd2   // 12 bit chip id
   } cfg_reg_e;

   // address group, dstaddr[10:8], that selects the config block
   localparam logic [2:0] cfg_group = 3'd2;

   // clock word after por: all clocks on, lowest speed
   localparam logic [15:0] clk_config_default = 16'h0573;

   // ########################################################################
   // link controller
   // ########################################################################

   // four-phase req/ack sequencing
   typedef enum logic [1:0] {
      ls_idle         = 2'd0,  // waiting for a queued packet
      ls_req          = 2'd1,  // tx_req high, waiting for ack rise
      ls_wait_ack_low = 2'd2   // req dropped, waiting for ack fall
   } link_state_e;

   // a fourth encoding is unused; fsm recovers to ls_idle
   // packet width follows from the struct
   // 1 + 2 + 5 + 32 + 32 + 32 = 104

endpackage

//--- design/elink_cfg.sv
// configuration decode for the transmit write port
// catches writes to the link's own registers, forwards everything else
// holds soft resets, clock word and chip id
`timescale 1ns/100ps

module elink_cfg
   import elink_pkg::*;
#(
   parameter logic [11:0] ID             = 12'h000, // this link's mesh id
   parameter logic [11:0] DEFAULT_CHIPID = 12'h808, // chip id after por
   parameter int          RFAW           = 6        // register address width
) (
   input  logic          clk,
   input  logic          por_reset,       // hard reset, async
   input  logic          txwr_access,     // write port valid
   input  emesh_packet_t txwr_packet,     // write port packet
   input  logic          txwr_wait,       // queue full, nothing accepted
   output logic          fwd_valid,       // push to tx queue
   output emesh_packet_t fwd_packet,      // packet for tx queue
   output logic          etx_soft_reset,  // tx soft reset (level)
   output logic          erx_soft_reset,  // rx soft reset (level)
   output logic [15:0]   clk_config,      // clock settings for pll
   output logic [11:0]   chipid           // chip id, full 12 bits
);

   logic            accept;     // handshake completes this edge
   logic            cfg_hit;    // accepted write into config space
   logic [RFAW-1:0] reg_index;  // register index from address
   logic            reset_wr;
   logic            clk_wr;
   logic            chipid_wr;
   logic            cfg_write;  // any of the three registers
   logic [1:0]      reset_reg;
   logic [15:0]     clk_reg;
   logic [11:0]     chipid_reg;

   // ########################################################################
   // address decode
   // ########################################################################

   assign accept    = txwr_access & ~txwr_wait;
   assign reg_index = txwr_packet.dstaddr[RFAW+1:2];

   // id in the top 12 bits, group in 10:8, writes only
   assign cfg_hit = accept & txwr_packet.write &
                    (txwr_packet.dstaddr[31:20] == ID) &
                    (txwr_packet.dstaddr[10:8] == cfg_group);

   // per register write strobes
   assign reset_wr  = cfg_hit & (reg_index == RFAW'(reg_reset));
   assign clk_wr    = cfg_hit & (reg_index == RFAW'(reg_clk));
   assign chipid_wr = cfg_hit & (reg_index == RFAW'(reg_chipid));

   assign cfg_write = reset_wr | clk_wr | chipid_wr;

   // ########################################################################
   // forward filter
   // ########################################################################

   // reads to config space and unknown indices still go out
   assign fwd_valid  = accept & ~cfg_write;
   assign fwd_packet = txwr_packet;  // forwarded untouched

   // ########################################################################
   // registers
   // ########################################################################

   // soft reset pair
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         reset_reg <= 2'b00;
      end else if (reset_wr) begin
         reset_reg <= txwr_packet.data[1:0];
      end
   end

   // clock word, consumed by the pll outside this block
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         clk_reg <= clk_config_default;
      end else if (clk_wr) begin
         clk_reg <= txwr_packet.data[15:0];
      end
   end

   // chip id
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         chipid_reg <= DEFAULT_CHIPID;
      end else if (chipid_wr) begin
         chipid_reg <= txwr_packet.data[11:0];
      end
   end

   assign etx_soft_reset = reset_reg[0];
   assign erx_soft_reset = reset_reg[1];
   assign clk_config     = clk_reg;
   assign chipid         = chipid_reg;  // all 12 bits presented

endmodule

//--- design/tx_fifo.sv
// transmit packet queue between the config filter and the link controller
// circular buffer, single clock, head visible one cycle after push
// flush empties it and blocks pushes while high
`timescale 1ns/100ps

module tx_fifo
   import elink_pkg::*;
#(
   parameter int DEPTH = 8  // entries, power of two
) (
   input  logic          clk,
   input  logic          por_reset,    // hard reset, async
   input  logic          flush,        // tx soft reset
   input  logic          push,         // write a packet
   input  emesh_packet_t push_packet,
   input  logic          pop,          // drop the head entry
   output emesh_packet_t head_packet,  // oldest entry
   output logic          not_empty,
   output logic          full          // becomes txwr_wait
);

   // pointer and count widths
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   emesh_packet_t mem [DEPTH];  // storage, no reset

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;   // occupancy 0..DEPTH
   logic          do_push;
   logic          do_pop;

   // ########################################################################
   // qualified strobes
   // ########################################################################

   assign do_push = push & ~full & ~flush;     // overflow guard
   assign do_pop  = pop & not_empty & ~flush;  // underflow guard

   // ########################################################################
   // storage
   // ########################################################################

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_packet;
      end
   end

   assign head_packet = mem[rd_ptr];

   // ########################################################################
   // pointers and count
   // ########################################################################

   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;  // drop everything
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2^n
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle or push+pop
         endcase
      end
   end

   // status flags
   assign not_empty = (count != '0);
   assign full      = (count == CW'(DEPTH));

endmodule

//--- design/tx_link_ctrl.sv
// link controller on the physical side of the transmit queue
// pops one packet at a time and hands it over a four-phase req/ack
// hold stops new transfers, a running one always completes
`timescale 1ns/100ps

module tx_link_ctrl
   import elink_pkg::*;
(
   input  logic          clk,
   input  logic          por_reset,    // hard reset, async
   input  logic          hold,         // tx soft reset, blocks new starts
   input  logic          not_empty,    // queue has a packet
   input  emesh_packet_t head_packet,  // queue head
   output logic          pop,          // one cycle, loads the head
   output logic          tx_req,       // four-phase request
   output emesh_packet_t tx_packet,    // stable while req/ack busy
   input  logic          tx_ack        // four-phase acknowledge
);

   link_state_e state;
   link_state_e state_nxt;
   logic        start;  // begin a new transfer this cycle

   // ########################################################################
   // start condition
   // ########################################################################

   // only from idle, never with ack still high from the peer
   assign start = (state == ls_idle) & not_empty & ~hold & ~tx_ack;
   assign pop   = start;

   // ########################################################################
   // next state
   // ########################################################################

   always_comb begin
      state_nxt = state;
      case (state)
         ls_idle: begin
            if (start) begin
               state_nxt = ls_req;  // req rises next cycle
            end
         end
         ls_req: begin
            // phase 2 seen, drop req
            if (tx_ack) begin
               state_nxt = ls_wait_ack_low;
            end
         end
         ls_wait_ack_low: begin
            // phase 4 seen, link free again
            if (!tx_ack) begin
               state_nxt = ls_idle;
            end
         end
         default: begin
            state_nxt = ls_idle;  // unused encoding
         end
      endcase
   end

   // ########################################################################
   // state and output registers
   // ########################################################################

   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         state <= ls_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // payload register, loaded only on pop
   // held through ls_req and ls_wait_ack_low
   always_ff @(posedge clk) begin
      if (start) begin
         tx_packet <= head_packet;
      end
   end

   // req is high for the whole of ls_req only
   assign tx_req = (state == ls_req);

endmodule

//--- design/elink_tx_top.sv
// transmit front end of the chip-to-chip link
// write port -> config filter -> packet queue -> four-phase link controller
// sets the parameters for all three blocks
`timescale 1ns/100ps

module elink_tx_top
   import elink_pkg::*;
#(
   parameter logic [11:0] ID             = 12'h000,
   parameter logic [11:0] DEFAULT_CHIPID = 12'h808,
   parameter int          RFAW           = 6,
   parameter int          DEPTH          = 8   // queue entries, power of two
) (
   input  logic          clk,
   input  logic          por_reset,
   input  logic          txwr_access,    // write port
   input  emesh_packet_t txwr_packet,
   output logic          txwr_wait,      // queue full
   output logic          tx_req,         // physical side
   output emesh_packet_t tx_packet,
   input  logic          tx_ack,
   output logic          etx_soft_reset,
   output logic          erx_soft_reset,
   output logic [15:0]   clk_config,
   output logic [11:0]   chipid
);

   logic          fwd_valid;    // cfg -> queue
   emesh_packet_t fwd_packet;
   emesh_packet_t head_packet;  // queue -> controller
   logic          not_empty;
   logic          pop;

   elink_cfg #(
      .ID             (ID),
      .DEFAULT_CHIPID (DEFAULT_CHIPID),
      .RFAW           (RFAW)
   ) u_cfg (
      .clk            (clk),
      .por_reset      (por_reset),
      .txwr_access    (txwr_access),
      .txwr_packet    (txwr_packet),
      .txwr_wait      (txwr_wait),
      .fwd_valid      (fwd_valid),
      .fwd_packet     (fwd_packet),
      .etx_soft_reset (etx_soft_reset),
      .erx_soft_reset (erx_soft_reset),
      .clk_config     (clk_config),
      .chipid         (chipid)
   );

   // tx soft reset flushes the queue
   tx_fifo #(
      .DEPTH       (DEPTH)
   ) u_fifo (
      .clk         (clk),
      .por_reset   (por_reset),
      .flush       (etx_soft_reset),
      .push        (fwd_valid),
      .push_packet (fwd_packet),
      .pop         (pop),
      .head_packet (head_packet),
      .not_empty   (not_empty),
      .full        (txwr_wait)
   );

   // and stalls new transfers
   tx_link_ctrl u_link (
      .clk         (clk),
      .por_reset   (por_reset),
      .hold        (etx_soft_reset),
      .not_empty   (not_empty),
      .head_packet (head_packet),
      .pop         (pop),
      .tx_req      (tx_req),
      .tx_packet   (tx_packet),
      .tx_ack      (tx_ack)
   );

endmodule

//--- bench/elink_checker.sv
// reference model and scoreboard for the elink transmit front end
// watches the DUT ports only and samples everything on the falling edge
`timescale 1ns/100ps

module elink_checker
   import elink_pkg::*;
#(
   parameter logic [11:0] ID             = 12'h000,
   parameter logic [11:0] DEFAULT_CHIPID = 12'h808,
   parameter int          DEPTH          = 8         // queue entries in the DUT
) (
   input  logic          clk,
   input  logic          por_reset,
   input  logic          txwr_access,
   input  emesh_packet_t txwr_packet,
   input  logic          txwr_wait,
   input  logic          tx_req,
   input  emesh_packet_t tx_packet,
   input  logic          tx_ack,
   input  logic          etx_soft_reset,
   input  logic          erx_soft_reset,
   input  logic [15:0]   clk_config,
   input  logic [11:0]   chipid,
   input  logic          end_of_test,  // run the closing checks
   output int            value_errs,
   output int            proto_errs,
   output int            pending       // packets not yet handed over
);

   emesh_packet_t exp_q[$];   // forwarded packets in acceptance order
   emesh_packet_t held;       // payload seen at req rise
   logic [1:0]    m_reset;    // model of the reset pair
   logic [15:0]   m_clk;
   logic [11:0]   m_chipid;
   logic          busy;       // inside a four-phase transfer
   logic          ack_seen;
   logic          prev_req;
   logic          prev_ack;
   logic          wait_seen;  // queue filled at least once
   logic          exp_wait;   // model of the queue full flag
   logic          final_done;

   // write to own id and group 2 with index 0..2 in address bits 7:2
   function automatic logic is_cfg_write(input emesh_packet_t p);
      return p.write && (p.dstaddr[31:20] == ID) && (p.dstaddr[10:8] == 3'd2) &&
             (p.dstaddr[7:2] < 6'd3);
   endfunction

   task automatic report_mismatch(input string name, input logic [103:0] expv, gotv);
      value_errs++;
      $display("FAILED %s expected %0h got %0h", name, expv, gotv);
   endtask

   task automatic report_protocol(input string what);
      proto_errs++;
      $display("protocol error at %0t ns: %s", $time, what);
   endtask

   always @(negedge clk) begin
      if (por_reset) begin
         m_reset    = 2'b00;
         m_clk      = 16'h0573;  // all clocks on at the slowest speed
         m_chipid   = DEFAULT_CHIPID;
         busy       = 1'b0;
         ack_seen   = 1'b0;
         prev_req   = 1'b0;
         prev_ack   = 1'b0;
         wait_seen  = 1'b0;
         final_done = 1'b0;
         exp_q.delete();
         if (tx_req !== 1'b0) report_mismatch("tx_req", 104'(0), 104'(tx_req));
      end else begin
         // ####################################################################
         // configuration outputs
         // ####################################################################
         if (etx_soft_reset !== m_reset[0])
            report_mismatch("etx_soft_reset", 104'(m_reset[0]), 104'(etx_soft_reset));
         if (erx_soft_reset !== m_reset[1])
            report_mismatch("erx_soft_reset", 104'(m_reset[1]), 104'(erx_soft_reset));
         if (clk_config !== m_clk) report_mismatch("clk_config", 104'(m_clk), 104'(clk_config));
         if (chipid !== m_chipid) report_mismatch("chipid", 104'(m_chipid), 104'(chipid));
         // ####################################################################
         // four-phase link side
         // ####################################################################
         if (tx_req && !prev_req) begin
            if (prev_ack) report_protocol("tx_req rose while tx_ack was still high");
            if (exp_q.size() == 0) begin
               report_protocol("tx_req rose with no forwarded packet pending");
            end else begin
               if (tx_packet !== exp_q[0]) report_mismatch("tx_packet", exp_q[0], tx_packet);
               void'(exp_q.pop_front());
            end
            busy     = 1'b1;
            held     = tx_packet;
            ack_seen = tx_ack;  // peer may answer at once
         end else if (busy) begin
            if (tx_packet !== held) report_mismatch("tx_packet (held)", held, tx_packet);
            if (tx_ack) ack_seen = 1'b1;
            if (!tx_req && !ack_seen) begin
               report_protocol("tx_req dropped before tx_ack rose");
               busy = 1'b0;
            end else if (!tx_req && !tx_ack) begin
               busy = 1'b0;  // phase 4 done
            end
         end
         // ####################################################################
         // write port effects that land on the next rising edge
         // ####################################################################
         if (txwr_wait) wait_seen = 1'b1;
         // queued entries match the DUT occupancy here
         exp_wait = (exp_q.size() == DEPTH);
         if (txwr_wait !== exp_wait)
            report_mismatch("txwr_wait", 104'(exp_wait), 104'(txwr_wait));
         if (m_reset[0]) begin
            exp_q.delete();  // queue flushed and pushes dropped
         end else if (txwr_access && !txwr_wait && !is_cfg_write(txwr_packet)) begin
            exp_q.push_back(txwr_packet);
         end
         if (txwr_access && !txwr_wait && is_cfg_write(txwr_packet)) begin
            case (txwr_packet.dstaddr[7:2])
               6'd0:    m_reset  = txwr_packet.data[1:0];
               6'd1:    m_clk    = txwr_packet.data[15:0];
               default: m_chipid = txwr_packet.data[11:0];
            endcase
         end
         if (end_of_test && !final_done) begin
            final_done = 1'b1;
            if (exp_q.size() != 0) report_protocol("forwarded packets never reached tx_packet");
            if (!wait_seen) report_protocol("txwr_wait never rose under slow acks");
         end
         prev_req = tx_req;
         prev_ack = tx_ack;
      end
      pending = exp_q.size() + int'(busy);
   end

endmodule

//--- bench/tb_elink.sv
// testbench for the elink transmit front end
// seeded random traffic on the write port and a random-delay ack on the link side
// elink_checker does all the comparing
`timescale 1ns/100ps

module tb_elink
   import elink_pkg::*;
();

   localparam logic [11:0] ID       = 12'h000;
   localparam int          depth    = 8;                 // queue entries
   localparam int          period   = 40;                // ns
   localparam int          num_rand = 60;                // packets per random phase
   localparam int          num_pkts = 2 * num_rand + 30;
   localparam int          max_ack  = 12;                // slowest peer, cycles

   logic          clk;
   logic          por_reset;
   logic          txwr_access;
   emesh_packet_t txwr_packet;
   logic          txwr_wait;
   logic          tx_req;
   emesh_packet_t tx_packet;
   logic          tx_ack;
   logic          etx_soft_reset;
   logic          erx_soft_reset;
   logic [15:0]   clk_config;
   logic [11:0]   chipid;
   logic          end_of_test;
   int            value_errs;
   int            proto_errs;
   int            pending;
   int            seed = 97;
   int            ack_max;      // current peer delay limit

   elink_tx_top #(.ID(ID), .DEFAULT_CHIPID(12'h808), .RFAW(6), .DEPTH(depth)) DUT (.*);

   elink_checker #(.ID(ID), .DEFAULT_CHIPID(12'h808), .DEPTH(depth)) u_check (.*);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // ########################################################################
   // stimulus helpers that start and end 2 ns after a rising edge
   // ########################################################################

   task automatic rand_below(input int n, output int v);
      v = int'({$random(seed)} % n);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   // hold the packet until an edge sees txwr_wait low
   task automatic send_packet(input emesh_packet_t p);
      logic stalled;
      txwr_access = 1'b1;
      txwr_packet = p;
      do begin
         @(negedge clk);
         stalled = txwr_wait;
         @(posedge clk);
         #2;
      end while (stalled);
      txwr_access = 1'b0;
   endtask

   // config writes, config reads, or misses on id / group / index
   task automatic random_packet(output emesh_packet_t p);
      int          kind;
      int          sel;
      logic [31:0] r;
      logic [11:0] id;
      logic [2:0]  grp;
      logic [5:0]  idx;
      rand_below(3, kind);
      r = $random(seed);
      id = ID;
      grp = 3'd2;
      p.write = r[31];
      p.datamode = r[30:29];
      p.ctrlmode = r[28:24];
      p.data = $random(seed);
      p.srcaddr = $random(seed);
      if (kind == 0) begin
         rand_below(2, sel);
         idx = 6'(sel + 1);  // clock word or chip id
         p.write = 1'b1;
      end else if (kind == 1) begin
         rand_below(4, sel);
         idx = 6'(sel);
         p.write = 1'b0;     // reads are always forwarded
      end else begin
         rand_below(4095, sel);
         idx = 6'(sel % 64);
         case (sel % 3)
            0:       id = ID + 12'(sel + 1);
            1:       grp = 3'd2 + 3'(sel % 7 + 1);
            default: idx = 6'(sel % 61 + 3);
         endcase
      end
      p.dstaddr = {id, r[8:0], grp, idx, r[10:9]};
   endtask

   task automatic write_reg(input logic [5:0] idx, input logic [31:0] d);
      emesh_packet_t p;
      p = '0;
      p.write = 1'b1;
      p.dstaddr = {ID, 9'h0, 3'd2, idx, 2'b00};
      p.data = d;
      send_packet(p);
   endtask

   // until the scoreboard is empty and the link is quiet
   task automatic drain_link();
      do begin
         @(posedge clk);
         #2;
      end while (pending != 0 || tx_req || tx_ack);
   endtask

   // ########################################################################
   // link side peer with a random delay on both ack edges
   // ########################################################################

   initial begin
      int d;
      @(negedge por_reset);
      forever begin
         @(posedge clk);
         #2;
         if (tx_req) begin
            rand_below(ack_max + 1, d);
            wait_cycles(d);
            tx_ack = 1'b1;
            do begin
               @(posedge clk);
               #2;
            end while (tx_req);
            rand_below(ack_max + 1, d);
            wait_cycles(d);
            tx_ack = 1'b0;
         end
      end
   end

   // worst case every packet waits two full ack delays
   initial begin
      #(num_pkts * (2 * max_ack + 8) * period + 200 * period);
      $display("watchdog expired before the test sequence finished");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      emesh_packet_t p;
      int            gap;
      por_reset = 1'b1;
      txwr_access = 1'b0;
      txwr_packet = '0;
      tx_ack = 1'b0;
      end_of_test = 1'b0;
      ack_max = 3;
      repeat (16) @(posedge clk);
      #2 por_reset = 1'b0;
      repeat (num_rand) begin  // mixed traffic with a quick peer
         random_packet(p);
         send_packet(p);
         rand_below(3, gap);
         wait_cycles(gap);
      end
      drain_link();
      ack_max = max_ack;  // slow peer fills the queue
      repeat (num_rand) begin
         random_packet(p);
         send_packet(p);
      end
      drain_link();
      ack_max = 3;
      write_reg(6'd1, 32'h0000_a5c3);
      write_reg(6'd2, 32'h0000_0123);
      write_reg(6'd0, 32'h1);  // tx soft reset on
      repeat (8) begin
         random_packet(p);
         send_packet(p);
      end
      wait_cycles(20);  // link must stay silent
      write_reg(6'd0, 32'h0);
      repeat (8) begin
         random_packet(p);
         send_packet(p);
      end
      drain_link();
      write_reg(6'd0, 32'h2);  // rx bit alone
      wait_cycles(3);
      write_reg(6'd0, 32'h0);
      wait_cycles(3);
      end_of_test = 1'b1;
      wait_cycles(2);
      $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
design/elink_pkg.sv
design/elink_cfg.sv
design/tx_fifo.sv
design/tx_link_ctrl.sv
design/elink_tx_top.sv
bench/elink_checker.sv
bench/tb_elink.sv

//--- Makefile
# Verilator build, run, lint and clean for the elink transmit front end

TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_elink
FLIST = all.f
BUILD = obj_dir
PASS  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)
